//--- rtl/count_up.sv
module count_up #(
  parameter int width = 16
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             enable,
  input  logic [width-1:0] target,
  output logic [width-1:0] value,
  output logic             wrap
);

  assign wrap = (value == target); // Terminal count

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else if (enable) begin
      if (wrap) begin
        value <= '0;
      end else begin
        value <= value + 1'b1;
      end
    end
  end

endmodule

//--- rtl/pattern_gen.sv
module pattern_gen (
  input  logic                  clock,
  input  logic                  arst_n,
  input  logic                  pix_stb,
  input  logic                  hsync_n,
  input  logic                  vsync_n,
  input  logic                  active,
  input  logic                  video_en,
  input  vid_pkg::vid_count_t   hcount,
  input  vid_pkg::vid_count_t   vcount,
  input  vid_pkg::vid_pattern_e pattern,
  input  vid_pkg::vid_rgb_t     fg,
  input  vid_pkg::vid_rgb_t     bg,
  output logic                  vid_hsync_n,
  output logic                  vid_vsync_n,
  output logic                  vid_de,
  output vid_pkg::vid_rgb_t     vid_rgb
);

  vid_pkg::vid_rgb_t pixel_rgb;
  logic [2:0]        bar;

  assign bar = hcount[7:5]; // 32 pixel wide bars

  always_comb begin
    if (!active || !video_en) begin
      pixel_rgb = '0; // Blanking or video off
    end else begin
      case (pattern)
        vid_pkg::PAT_SOLID: begin
          pixel_rgb = fg;
        end
        vid_pkg::PAT_BARS: begin
          pixel_rgb = {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
        end
        vid_pkg::PAT_CHECKER: begin
          pixel_rgb = (hcount[4] ^ vcount[4]) ? fg : bg; // 16x16 squares
        end
        vid_pkg::PAT_GRADIENT: begin
          pixel_rgb = {hcount[7:0], vcount[7:0], fg[7:0]};
        end
        default: begin
          pixel_rgb = '0;
        end
      endcase
    end
  end

  // Sync and enable delayed with the colour so all outputs stay aligned
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      vid_hsync_n <= 1'b1;
      vid_vsync_n <= 1'b1;
      vid_de      <= 1'b0;
      vid_rgb     <= '0;
    end else if (pix_stb) begin
      vid_hsync_n <= hsync_n;
      vid_vsync_n <= vsync_n;
      vid_de      <= active;
      vid_rgb     <= pixel_rgb;
    end
  end

endmodule

//--- rtl/vid_apb_regs.sv
`include "vid_defines.svh"

module vid_apb_regs (
  input  logic                  clock,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  vid_pkg::vid_addr_t    paddr,
  input  vid_pkg::vid_word_t    pwdata,
  input  logic                  frame_start,
  output vid_pkg::vid_word_t    prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  video_en,
  output vid_pkg::vid_pattern_e pattern,
  output vid_pkg::vid_rgb_t     fg,
  output vid_pkg::vid_rgb_t     bg
);

  logic                  access;
  logic                  mapped;
  logic                  ctrl_en;
  vid_pkg::vid_pattern_e ctrl_pat;
  vid_pkg::vid_rgb_t     fg_reg;
  vid_pkg::vid_rgb_t     bg_reg;
  vid_pkg::vid_count_t   frame_cnt;

  assign access = psel & penable;
  assign pready = 1'b1; // No wait states

  assign mapped = (paddr == `VID_ADDR_CTRL) || (paddr == `VID_ADDR_FG) ||
                  (paddr == `VID_ADDR_BG)   || (paddr == `VID_ADDR_STATUS);

  // STATUS is read only
  assign pslverr = access & (~mapped | (pwrite & (paddr == `VID_ADDR_STATUS)));

  always_comb begin
    case (paddr)
      `VID_ADDR_CTRL:   prdata = {29'd0, ctrl_pat, ctrl_en};
      `VID_ADDR_FG:     prdata = {8'd0, fg_reg};
      `VID_ADDR_BG:     prdata = {8'd0, bg_reg};
      `VID_ADDR_STATUS: prdata = {16'd0, frame_cnt};
      default:          prdata = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_en  <= 1'b0;
      ctrl_pat <= vid_pkg::PAT_SOLID;
      fg_reg   <= '0;
      bg_reg   <= '0;
    end else if (access && pwrite && !pslverr) begin
      case (paddr)
        `VID_ADDR_CTRL: begin
          ctrl_en  <= pwdata[0];
          ctrl_pat <= vid_pkg::vid_pattern_e'(pwdata[2:1]);
        end
        `VID_ADDR_FG: fg_reg <= pwdata[23:0];
        `VID_ADDR_BG: bg_reg <= pwdata[23:0];
        default: ;
      endcase
    end
  end

  // Shadow copies seen by the video path, updated only between frames
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      video_en  <= 1'b0;
      pattern   <= vid_pkg::PAT_SOLID;
      fg        <= '0;
      bg        <= '0;
      frame_cnt <= '0;
    end else if (frame_start) begin
      video_en  <= ctrl_en;
      pattern   <= ctrl_pat;
      fg        <= fg_reg;
      bg        <= bg_reg;
      frame_cnt <= frame_cnt + 1'b1; // Wraps at 16 bits
    end
  end

endmodule

//--- rtl/vid_defines.svh
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// Horizontal geometry in pixels
`define VID_H_ACTIVE 256
`define VID_H_FRONT  18
`define VID_H_SYNC   25
`define VID_H_BACK   42
`define VID_H_TOTAL  (`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)

// Vertical geometry in lines
`define VID_V_ACTIVE 240
`define VID_V_FRONT  5
`define VID_V_SYNC   3
`define VID_V_BACK   14
`define VID_V_TOTAL  (`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

// Pixel strobe divider, one strobe per 2**VID_DIV_W clocks
`define VID_DIV_W 2

// APB register map, byte addresses
`define VID_ADDR_CTRL   4'h0
`define VID_ADDR_FG     4'h4
`define VID_ADDR_BG     4'h8
`define VID_ADDR_STATUS 4'hC

`endif

//--- rtl/vid_pkg.sv
package vid_pkg;

  // Pixel or line position
  typedef logic [15:0] vid_count_t;

  // Colour as {red, green, blue}
  typedef logic [23:0] vid_rgb_t;

  // APB byte address and data
  typedef logic [3:0]  vid_addr_t;
  typedef logic [31:0] vid_word_t;

  // Test pattern selection, CTRL bits 2:1
  typedef enum logic [1:0] {
    PAT_SOLID    = 2'd0,
    PAT_BARS     = 2'd1,
    PAT_CHECKER  = 2'd2,
    PAT_GRADIENT = 2'd3
  } vid_pattern_e;

endpackage

//--- rtl/vid_top.sv
module vid_top (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  vid_pkg::vid_addr_t paddr,
  input  vid_pkg::vid_word_t pwdata,
  output vid_pkg::vid_word_t prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               pix_stb,
  output logic               vid_hsync_n,
  output logic               vid_vsync_n,
  output logic               vid_de,
  output vid_pkg::vid_rgb_t  vid_rgb
);

  logic                  frame_start;
  logic                  hsync_n;
  logic                  vsync_n;
  logic                  active;
  vid_pkg::vid_count_t   hcount;
  vid_pkg::vid_count_t   vcount;
  logic                  video_en;
  vid_pkg::vid_pattern_e pattern;
  vid_pkg::vid_rgb_t     fg;
  vid_pkg::vid_rgb_t     bg;

  video_timing u_timing (
    .clock       (clock),
    .arst_n      (arst_n),
    .pix_stb     (pix_stb),
    .frame_start (frame_start),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n),
    .active      (active),
    .hcount      (hcount),
    .vcount      (vcount)
  );

  vid_apb_regs u_regs (
    .clock       (clock),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .frame_start (frame_start),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .video_en    (video_en),
    .pattern     (pattern),
    .fg          (fg),
    .bg          (bg)
  );

  pattern_gen u_pattern (
    .clock       (clock),
    .arst_n      (arst_n),
    .pix_stb     (pix_stb),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n),
    .active      (active),
    .video_en    (video_en),
    .hcount      (hcount),
    .vcount      (vcount),
    .pattern     (pattern),
    .fg          (fg),
    .bg          (bg),
    .vid_hsync_n (vid_hsync_n),
    .vid_vsync_n (vid_vsync_n),
    .vid_de      (vid_de),
    .vid_rgb     (vid_rgb)
  );

endmodule

//--- rtl/video_timing.sv
`include "vid_defines.svh"

module video_timing (
  input  logic                clock,
  input  logic                arst_n,
  output logic                pix_stb,
  output logic                frame_start,
  output logic                hsync_n,
  output logic                vsync_n,
  output logic                active,
  output vid_pkg::vid_count_t hcount,
  output vid_pkg::vid_count_t vcount
);

  localparam vid_pkg::vid_count_t H_LAST =
    vid_pkg::vid_count_t'(`VID_H_TOTAL - 1);
  localparam vid_pkg::vid_count_t V_LAST =
    vid_pkg::vid_count_t'(`VID_V_TOTAL - 1);

  localparam vid_pkg::vid_count_t H_ACTIVE   = vid_pkg::vid_count_t'(`VID_H_ACTIVE);
  localparam vid_pkg::vid_count_t V_ACTIVE   = vid_pkg::vid_count_t'(`VID_V_ACTIVE);

  // Sync windows, begin inclusive and end exclusive
  localparam vid_pkg::vid_count_t H_SYNC_BEG =
    vid_pkg::vid_count_t'(`VID_H_ACTIVE + `VID_H_FRONT);
  localparam vid_pkg::vid_count_t H_SYNC_END =
    vid_pkg::vid_count_t'(`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC);
  localparam vid_pkg::vid_count_t V_SYNC_BEG =
    vid_pkg::vid_count_t'(`VID_V_ACTIVE + `VID_V_FRONT);
  localparam vid_pkg::vid_count_t V_SYNC_END =
    vid_pkg::vid_count_t'(`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC);

  logic h_wrap;
  logic v_wrap;
  logic h_in_sync;
  logic v_in_sync;

  count_up #(
    .width(`VID_DIV_W)
  ) u_div (
    .clock  (clock),
    .arst_n (arst_n),
    .enable (1'b1),
    .target ({`VID_DIV_W{1'b1}}),
    .value  (),
    .wrap   (pix_stb) // High on the last divider state
  );

  count_up #(
    .width(16)
  ) u_hcount (
    .clock  (clock),
    .arst_n (arst_n),
    .enable (pix_stb),
    .target (H_LAST),
    .value  (hcount),
    .wrap   (h_wrap)
  );

  count_up #(
    .width(16)
  ) u_vcount (
    .clock  (clock),
    .arst_n (arst_n),
    .enable (pix_stb & h_wrap), // One line per horizontal wrap
    .target (V_LAST),
    .value  (vcount),
    .wrap   (v_wrap)
  );

  assign h_in_sync = (hcount >= H_SYNC_BEG) && (hcount < H_SYNC_END);
  assign v_in_sync = (vcount >= V_SYNC_BEG) && (vcount < V_SYNC_END);

  assign hsync_n = ~h_in_sync; // Active low
  assign vsync_n = ~v_in_sync;
  assign active  = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);

  // Last strobe of a frame, the one that moves the position back to (0,0).
  // Configuration loaded here is in place when pixel 0 is registered.
  assign frame_start = pix_stb & h_wrap & v_wrap;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the video source testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module vid_tb \
  --Mdir obj_dir -o vid_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/vid_sim > sim.log 2>&1
run_status=$?

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status, see sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- sim.f
+incdir+rtl
rtl/vid_pkg.sv
rtl/count_up.sv
rtl/video_timing.sv
rtl/vid_apb_regs.sv
rtl/pattern_gen.sv
rtl/vid_top.sv
tb/vid_checker.sv
tb/vid_tb.sv

//--- tb/vid_checker.sv
module vid_checker (
  input logic clock,
  input logic arst_n,
  input logic pix_stb,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic vid_hsync_n
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0] hsync_low_len;
  int unsigned error_count = 0; // Number of failed assertions

  // Strobes seen while the registered hsync was low
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      hsync_low_len <= '0;
    end else if (pix_stb) begin
      if (!vid_hsync_n) begin
        hsync_low_len <= hsync_low_len + 16'd1;
      end else begin
        hsync_low_len <= '0;
      end
    end
  end

  strobe_spacing: assert property (@(posedge clock) disable iff (!arst_n)
    pix_stb |=> !pix_stb ##1 !pix_stb ##1 !pix_stb ##1 pix_stb)
    else begin
      error_count++;
      $error("pixel strobe spacing is not 4 cycles");
    end

  hsync_width: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(vid_hsync_n) |-> (hsync_low_len == 16'd25))
    else begin
      error_count++;
      $error("hsync low pulse is not 25 strobes long");
    end

  slverr_in_access: assert property (@(posedge clock) disable iff (!arst_n)
    pslverr |-> (psel && penable))
    else begin
      error_count++;
      $error("pslverr outside an access cycle");
    end

  ready_high: assert property (@(posedge clock) disable iff (!arst_n)
    pready)
    else begin
      error_count++;
      $error("pready went low");
    end

endmodule

bind vid_top vid_checker u_checker (
  .clock       (clock),
  .arst_n      (arst_n),
  .pix_stb     (pix_stb),
  .psel        (psel),
  .penable     (penable),
  .pready      (pready),
  .pslverr     (pslverr),
  .vid_hsync_n (vid_hsync_n)
);

//--- tb/vid_tb.sv
`include "vid_defines.svh"

module vid_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_TOTAL      = `VID_H_TOTAL;
  localparam int V_TOTAL      = `VID_V_TOTAL;
  localparam int FRAME_PIX    = H_TOTAL * V_TOTAL;
  localparam int STB_PERIOD   = 1 << `VID_DIV_W;
  localparam int FRAME_CYCLES = FRAME_PIX * STB_PERIOD;
  localparam longint WATCHDOG_NS = (5 * longint'(FRAME_CYCLES) + 20000) * 8;

  logic        clock = 1'b0;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        pix_stb;
  logic        vid_hsync_n;
  logic        vid_vsync_n;
  logic        vid_de;
  logic [23:0] vid_rgb;

  // Configuration as written over APB, and the one used by the current frame
  logic        pend_en = 1'b0;
  logic [1:0]  pend_pat = 2'd0;
  logic [23:0] pend_fg = '0;
  logic [23:0] pend_bg = '0;
  logic        cur_en = 1'b0;
  logic [1:0]  cur_pat = 2'd0;
  logic [23:0] cur_fg = '0;
  logic [23:0] cur_bg = '0;

  // Expected outputs after the previous strobe, reset values at first
  logic        exp_hs = 1'b1;
  logic        exp_vs = 1'b1;
  logic        exp_de = 1'b0;
  logic [23:0] exp_rgb = '0;

  int          stb_idx = 0;
  int          cyc_idx = 0; // Clock cycles since reset release
  int          frames_seen = 0;
  logic        fs_due = 1'b0;
  logic [31:0] rng_state = 32'heffae8d2;

  vid_top u_vid_top (
    .clock       (clock),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .pix_stb     (pix_stb),
    .vid_hsync_n (vid_hsync_n),
    .vid_vsync_n (vid_vsync_n),
    .vid_de      (vid_de),
    .vid_rgb     (vid_rgb)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [23:0] rand_colour();
    rng_state = xorshift32(rng_state);
    return rng_state[23:0];
  endfunction

  // Expected outputs for a pixel index under a configuration
  function automatic void ref_pixel(input int idx, input logic en, input logic [1:0] pat,
                                    input logic [23:0] fg, input logic [23:0] bg,
                                    output logic hs, output logic vs, output logic de,
                                    output logic [23:0] rgb);
    int          h;
    int          v;
    logic [15:0] hv;
    logic [15:0] vv;
    h = idx % H_TOTAL;
    v = (idx / H_TOTAL) % V_TOTAL;
    hv = 16'(h);
    vv = 16'(v);
    hs = !((h >= `VID_H_ACTIVE + `VID_H_FRONT) &&
           (h < `VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC));
    vs = !((v >= `VID_V_ACTIVE + `VID_V_FRONT) &&
           (v < `VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC));
    de = (h < `VID_H_ACTIVE) && (v < `VID_V_ACTIVE);
    if (!de || !en) begin
      rgb = '0;
    end else if (pat == 2'd0) begin
      rgb = fg;
    end else if (pat == 2'd1) begin
      rgb = {{8{hv[7]}}, {8{hv[6]}}, {8{hv[5]}}};
    end else if (pat == 2'd2) begin
      rgb = (hv[4] ^ vv[4]) ? fg : bg;
    end else begin
      rgb = {hv[7:0], vv[7:0], fg[7:0]};
    end
  endfunction

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_outputs();
    assert (vid_hsync_n == exp_hs) else begin
      $display("MISMATCH time=%0t signal=vid_hsync_n expected=%b actual=%b", $time,
               exp_hs, vid_hsync_n);
      stop_on_error();
    end
    assert (vid_vsync_n == exp_vs) else begin
      $display("MISMATCH time=%0t signal=vid_vsync_n expected=%b actual=%b", $time,
               exp_vs, vid_vsync_n);
      stop_on_error();
    end
    assert (vid_de == exp_de) else begin
      $display("MISMATCH time=%0t signal=vid_de expected=%b actual=%b", $time,
               exp_de, vid_de);
      stop_on_error();
    end
    assert (vid_rgb == exp_rgb) else begin
      $display("MISMATCH time=%0t signal=vid_rgb expected=%h actual=%h", $time,
               exp_rgb, vid_rgb);
      stop_on_error();
    end
  endtask

  // Outputs are stable at the falling edge before each strobe edge
  always @(negedge clock) begin
    if (arst_n) begin
      cyc_idx++;
      assert (u_vid_top.u_checker.error_count == 0) else begin
        $display("A bound checker assertion failed before time %0t", $time);
        stop_on_error();
      end
      // First strobe in the 4th cycle after reset, then every 4th cycle
      assert (pix_stb == (cyc_idx % STB_PERIOD == 0)) else begin
        $display("MISMATCH time=%0t signal=pix_stb expected=%b actual=%b", $time,
                 (cyc_idx % STB_PERIOD == 0), pix_stb);
        stop_on_error();
      end
    end
    if (arst_n && pix_stb) begin
      check_outputs();
      ref_pixel(stb_idx, cur_en, cur_pat, cur_fg, cur_bg, exp_hs, exp_vs, exp_de, exp_rgb);
      if (stb_idx % FRAME_PIX == FRAME_PIX - 1) begin
        cur_en  = pend_en; // Shadow load on the last pixel of a frame
        cur_pat = pend_pat;
        cur_fg  = pend_fg;
        cur_bg  = pend_bg;
        fs_due  = 1'b1;
      end
      stb_idx++;
    end
  end

  // Frame counter moves on the strobe edge itself
  always @(posedge clock) begin
    if (fs_due) begin
      frames_seen++;
      fs_due = 1'b0;
    end
  end

  task automatic check_err(input string what, input logic got, input logic expected);
    assert (got == expected) else begin
      $display("MISMATCH time=%0t signal=pslverr (%s) expected=%b actual=%b", $time, what,
               expected, got);
      stop_on_error();
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic expect_err);
    logic err;
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    err = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    check_err("write", err, expect_err);
    if (!err) begin
      case (addr)
        `VID_ADDR_CTRL: begin
          pend_en  = data[0];
          pend_pat = data[2:1];
        end
        `VID_ADDR_FG: pend_fg = data[23:0];
        `VID_ADDR_BG: pend_bg = data[23:0];
        default: ;
      endcase
    end
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    data = prdata;
    err  = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_and_check(input string name, input logic [3:0] addr,
                                input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_err(name, err, 1'b0);
    assert (data == expected) else begin
      $display("MISMATCH time=%0t signal=prdata (%s) expected=%h actual=%h", $time, name,
               expected, data);
      stop_on_error();
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the video frames did not finish in time");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] data;
    logic        err;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clock);
    arst_n <= 1'b1;

    // Frame 0 is black; solid colour from frame 1
    apb_write(`VID_ADDR_FG, {8'd0, rand_colour()}, 1'b0);
    apb_write(`VID_ADDR_CTRL, 32'h1, 1'b0);
    wait (frames_seen == 1);
    apb_write(`VID_ADDR_CTRL, 32'h3, 1'b0); // Bars in frame 2
    wait (frames_seen == 2);
    apb_write(`VID_ADDR_FG, {8'd0, rand_colour()}, 1'b0);
    apb_write(`VID_ADDR_BG, {8'd0, rand_colour()}, 1'b0);
    apb_write(`VID_ADDR_CTRL, 32'h5, 1'b0); // Checker in frame 3
    wait (frames_seen == 3);
    apb_write(`VID_ADDR_CTRL, 32'h7, 1'b0); // Gradient in frame 4
    wait (frames_seen == 4);

    // Mid-frame change must wait for frame 5
    wait (stb_idx >= 4 * FRAME_PIX + 30000);
    apb_write(`VID_ADDR_CTRL, 32'h5, 1'b0);
    read_and_check("ctrl", `VID_ADDR_CTRL, {29'd0, pend_pat, pend_en});
    read_and_check("fg", `VID_ADDR_FG, {8'd0, pend_fg});
    read_and_check("bg", `VID_ADDR_BG, {8'd0, pend_bg});
    read_and_check("status", `VID_ADDR_STATUS, 32'(frames_seen));
    apb_read(4'hE, data, err);
    check_err("unmapped read", err, 1'b1);
    apb_write(`VID_ADDR_STATUS, 32'h1234, 1'b1);

    wait (frames_seen == 5);
    wait (stb_idx >= 5 * FRAME_PIX + 2000);
    read_and_check("status", `VID_ADDR_STATUS, 32'(frames_seen));

    if (u_vid_top.u_checker.error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
